/* verilog/tcdm_mem_pkg.sv */
/*
 * tcdm memory types: data word, byte enables, byte address and the word/lane union
 */
`default_nettype none

package tcdm_mem_pkg;

  localparam int unsigned WordBytes = 4;

  typedef logic [8*WordBytes-1:0] tcdm_word_t;
  typedef logic [WordBytes-1:0]   tcdm_be_t;
  typedef logic [31:0]            tcdm_addr_t;

  // one word, either whole or as byte lanes
  typedef union packed {
    tcdm_word_t                  word;
    logic [WordBytes-1:0][7:0]   lane;
  } tcdm_word_u;

  localparam int unsigned LfsrWidth = 16; // per-port stall lfsr

endpackage

`default_nettype wire

/* verilog/tcdm_apb_pkg.sv */
/*
 * apb control register map and field types for the tcdm scratchpad
 */
`default_nettype none

package tcdm_apb_pkg;

  typedef logic [11:0] apb_addr_t;

  localparam apb_addr_t RegCtrl      = 12'h000;
  localparam apb_addr_t RegStallThr  = 12'h004;
  localparam apb_addr_t RegSeed      = 12'h008;
  localparam apb_addr_t RegRdCntBase = 12'h010; // 4 bytes per port
  localparam apb_addr_t RegWrCntBase = 12'h020; // 4 bytes per port

  localparam int unsigned MaxPorts = 4;

  // stall threshold covers 0 .. 1024
  localparam int unsigned StallThrWidth = 11;

  typedef struct packed {
    logic stallable;
    logic enable;
  } ctrl_t;

endpackage

`default_nettype wire

/* verilog/tcdm_port_if.sv */
/*
 * one granted tcdm request per port, shared by decode, bank and result stage
 */
`timescale 1ns/1ps
`default_nettype none

interface tcdm_port_if #(
  parameter int unsigned MemWords = 256
);
  import tcdm_mem_pkg::*;

  localparam int unsigned IdxWidth = (MemWords > 1) ? $clog2(MemWords) : 1;

  logic                valid;    // granted this cycle
  logic                wen;      // 1 = read
  logic [IdxWidth-1:0] idx;
  tcdm_be_t            be;
  tcdm_word_t          wdata;
  logic                in_range;
  tcdm_word_t          rdata;    // stored or merged word

  modport decode (output valid, wen, idx, be, wdata, in_range);
  modport bank   (input valid, wen, idx, be, wdata, in_range, output rdata);
  modport result (input valid, wen, in_range, rdata);

endinterface

`default_nettype wire

/* verilog/tcdm_cfg_regs.sv */
/*
 * apb slave for the scratchpad: control, stall threshold, lfsr seed,
 * and readback of the per-port read/write counters
 */
`timescale 1ns/1ps
`default_nettype none

module tcdm_cfg_regs #(
  parameter int unsigned NumPorts = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  tcdm_apb_pkg::apb_addr_t                 paddr_i,
  input  logic                                    psel_i,
  input  logic                                    penable_i,
  input  logic                                    pwrite_i,
  input  logic [31:0]                             pwdata_i,
  output logic [31:0]                             prdata_o,
  output logic                                    pready_o,
  output logic                                    pslverr_o,
  output tcdm_apb_pkg::ctrl_t                     ctrl_o,
  output logic [tcdm_apb_pkg::StallThrWidth-1:0]  stall_thr_o,
  output logic [tcdm_mem_pkg::LfsrWidth-1:0]      seed_o,
  output logic                                    seed_load_o,
  input  logic [NumPorts-1:0][31:0]               rd_cnt_i,
  input  logic [NumPorts-1:0][31:0]               wr_cnt_i
);
  import tcdm_apb_pkg::*;
  import tcdm_mem_pkg::*;

  localparam apb_addr_t   CntSpan     = apb_addr_t'(4 * MaxPorts);
  localparam int unsigned CntIdxWidth = $clog2(MaxPorts);

  ctrl_t                    ctrl_q;
  logic [StallThrWidth-1:0] thr_q;
  logic [LfsrWidth-1:0]     seed_q;
  logic                     seed_load_q;

  logic                   access, wr_access;
  logic                   hit_ctrl, hit_thr, hit_seed, hit_rd_cnt, hit_wr_cnt;
  apb_addr_t              cnt_off;
  logic [CntIdxWidth-1:0] cnt_idx;
  logic                   cnt_valid;

  assign access    = psel_i & penable_i;
  assign wr_access = access & pwrite_i;

  assign hit_ctrl   = (paddr_i == RegCtrl);
  assign hit_thr    = (paddr_i == RegStallThr);
  assign hit_seed   = (paddr_i == RegSeed);
  assign hit_rd_cnt = (paddr_i >= RegRdCntBase) && (paddr_i < RegRdCntBase + CntSpan) &&
                      (paddr_i[1:0] == 2'b00);
  assign hit_wr_cnt = (paddr_i >= RegWrCntBase) && (paddr_i < RegWrCntBase + CntSpan) &&
                      (paddr_i[1:0] == 2'b00);

  assign cnt_off   = hit_rd_cnt ? paddr_i - RegRdCntBase : paddr_i - RegWrCntBase;
  assign cnt_idx   = cnt_off[CntIdxWidth+1:2];
  assign cnt_valid = (int'(cnt_idx) < NumPorts);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q      <= '0;
      thr_q       <= '0;
      seed_q      <= '0;
      seed_load_q <= 1'b0;
    end else begin
      seed_load_q <= wr_access & hit_seed; // lfsrs reload one cycle later
      if (wr_access & hit_ctrl) ctrl_q <= ctrl_t'(pwdata_i[$bits(ctrl_t)-1:0]);
      if (wr_access & hit_thr)  thr_q  <= pwdata_i[StallThrWidth-1:0];
      if (wr_access & hit_seed) seed_q <= pwdata_i[LfsrWidth-1:0];
    end
  end

  // read mux and error flag, valid in the access phase
  always_comb begin
    prdata_o  = '0;
    pslverr_o = 1'b0;
    if (access) begin
      if (hit_ctrl) begin
        prdata_o = 32'(ctrl_q);
      end else if (hit_thr) begin
        prdata_o = 32'(thr_q);
      end else if (hit_seed) begin
        prdata_o = 32'(seed_q);
      end else if (hit_rd_cnt || hit_wr_cnt) begin
        pslverr_o = pwrite_i | ~cnt_valid; // counters are read only
        if (cnt_valid && !pwrite_i) prdata_o = hit_rd_cnt ? rd_cnt_i[cnt_idx] : wr_cnt_i[cnt_idx];
      end else begin
        pslverr_o = 1'b1;
      end
    end
  end

  assign pready_o    = 1'b1;
  assign ctrl_o      = ctrl_q;
  assign stall_thr_o = thr_q;
  assign seed_o      = seed_q;
  assign seed_load_o = seed_load_q;

endmodule

`default_nettype wire

/* verilog/tcdm_req_decode.sv */
/*
 * per-port request decode: lfsr driven random stall, grant and address range check
 */
`timescale 1ns/1ps
`default_nettype none

module tcdm_req_decode #(
  parameter int unsigned              PortIdx  = 0,
  parameter int unsigned              MemWords = 256,
  parameter tcdm_mem_pkg::tcdm_addr_t BaseAddr = '0
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    req_i,
  input  tcdm_mem_pkg::tcdm_addr_t                add_i,
  input  logic                                    wen_i,
  input  tcdm_mem_pkg::tcdm_be_t                  be_i,
  input  tcdm_mem_pkg::tcdm_word_t                data_i,
  output logic                                    gnt_o,
  input  tcdm_apb_pkg::ctrl_t                     ctrl_i,
  input  logic [tcdm_apb_pkg::StallThrWidth-1:0]  stall_thr_i,
  input  logic [tcdm_mem_pkg::LfsrWidth-1:0]      seed_i,
  input  logic                                    seed_load_i,
  tcdm_port_if.decode                             port
);
  import tcdm_mem_pkg::*;
  import tcdm_apb_pkg::*;

  localparam int unsigned IdxWidth = (MemWords > 1) ? $clog2(MemWords) : 1;

  // x^16 + x^14 + x^13 + x^11 + 1
  localparam logic [LfsrWidth-1:0] LfsrTaps = 16'hB400;
  localparam logic [LfsrWidth-1:0] PortSalt = LfsrWidth'(PortIdx + 1);
  localparam logic [LfsrWidth-1:0] LfsrInit = 16'hACE1 ^ PortSalt;

  logic [LfsrWidth-1:0]     lfsr_q, lfsr_next, seed_mix;
  logic [StallThrWidth-1:0] lfsr_low;
  logic                     stall;
  tcdm_addr_t               offset;
  logic [29:0]              word_off;

  assign lfsr_next = {1'b0, lfsr_q[LfsrWidth-1:1]} ^ ({LfsrWidth{lfsr_q[0]}} & LfsrTaps);
  assign seed_mix  = seed_i ^ PortSalt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= LfsrInit;
    end else if (seed_load_i) begin
      lfsr_q <= (seed_mix == '0) ? LfsrInit : seed_mix; // never lock up at zero
    end else begin
      lfsr_q <= lfsr_next;
    end
  end

  assign lfsr_low = StallThrWidth'(lfsr_q[9:0]);
  assign stall    = ctrl_i.stallable & (lfsr_low < stall_thr_i);
  assign gnt_o    = req_i & ctrl_i.enable & ~stall;

  // byte address to word index
  assign offset   = add_i - BaseAddr;
  assign word_off = offset[31:2];

  assign port.valid    = gnt_o;
  assign port.wen      = wen_i;
  assign port.idx      = word_off[IdxWidth-1:0];
  assign port.be       = be_i;
  assign port.wdata    = data_i;
  assign port.in_range = (add_i >= BaseAddr) && (word_off < MemWords);

endmodule

`default_nettype wire

/* verilog/tcdm_mem_bank.sv */
/*
 * scratchpad word array with per-port byte-enable merge;
 * same-cycle writes to one word resolve to the highest port
 */
`timescale 1ns/1ps
`default_nettype none

module tcdm_mem_bank #(
  parameter int unsigned NumPorts = 2,
  parameter int unsigned MemWords = 256
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  tcdm_port_if.bank ports [NumPorts]
);
  import tcdm_mem_pkg::*;

  localparam int unsigned IdxWidth = (MemWords > 1) ? $clog2(MemWords) : 1;

  tcdm_word_t          mem_q [MemWords];

  logic                wr_en  [NumPorts];
  logic [IdxWidth-1:0] wr_idx [NumPorts];
  tcdm_word_t          wr_word[NumPorts];

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    tcdm_word_u cur_word, wr_lanes, merged;

    always_comb begin
      cur_word.word = mem_q[ports[p].idx];
      wr_lanes.word = ports[p].wdata;
      merged        = cur_word;
      for (int b = 0; b < WordBytes; b++) begin
        if (ports[p].be[b]) merged.lane[b] = wr_lanes.lane[b];
      end
    end

    assign ports[p].rdata = ports[p].wen ? cur_word.word : merged.word;

    // no writes while reset is held or outside the array
    assign wr_en[p]   = rst_ni & ports[p].valid & ~ports[p].wen & ports[p].in_range;
    assign wr_idx[p]  = ports[p].idx;
    assign wr_word[p] = merged.word;
  end

  // later ports overwrite earlier ones on the same word
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NumPorts; p++) begin
      if (wr_en[p]) mem_q[wr_idx[p]] <= wr_word[p];
    end
  end

endmodule

`default_nettype wire

/* verilog/tcdm_resp_stage.sv */
/*
 * tcdm response registers, one cycle after grant, plus per-port
 * counters of granted reads and writes
 */
`timescale 1ns/1ps
`default_nettype none

module tcdm_resp_stage #(
  parameter int unsigned NumPorts = 2
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  tcdm_port_if.result                            ports [NumPorts],
  output tcdm_mem_pkg::tcdm_word_t [NumPorts-1:0] r_data_o,
  output logic [NumPorts-1:0]                    r_valid_o,
  output logic [NumPorts-1:0][31:0]              rd_cnt_o,
  output logic [NumPorts-1:0][31:0]              wr_cnt_o
);
  import tcdm_mem_pkg::*;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    tcdm_word_t  data_q;
    logic        valid_q;
    logic [31:0] rd_cnt_q, wr_cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q  <= 1'b0;
        rd_cnt_q <= '0;
        wr_cnt_q <= '0;
      end else begin
        valid_q <= ports[p].valid;
        if (ports[p].valid && ports[p].wen)  rd_cnt_q <= rd_cnt_q + 32'd1; // wraps
        if (ports[p].valid && !ports[p].wen) wr_cnt_q <= wr_cnt_q + 32'd1;
      end
    end

    // out of range returns zero
    always_ff @(posedge clk_i) begin
      if (ports[p].valid) data_q <= ports[p].in_range ? ports[p].rdata : '0;
    end

    assign r_data_o[p]  = data_q;
    assign r_valid_o[p] = valid_q;
    assign rd_cnt_o[p]  = rd_cnt_q;
    assign wr_cnt_o[p]  = wr_cnt_q;
  end

endmodule

`default_nettype wire

/* verilog/tcdm_mem_top.sv */
/*
 * multi-port tcdm scratchpad with random grant stall and apb control port
 */
`timescale 1ns/1ps
`default_nettype none

module tcdm_mem_top #(
  parameter int unsigned              NumPorts = 2,
  parameter int unsigned              MemWords = 256,
  parameter tcdm_mem_pkg::tcdm_addr_t BaseAddr = '0
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // apb
  input  tcdm_apb_pkg::apb_addr_t                 paddr_i,
  input  logic                                    psel_i,
  input  logic                                    penable_i,
  input  logic                                    pwrite_i,
  input  logic [31:0]                             pwdata_i,
  output logic [31:0]                             prdata_o,
  output logic                                    pready_o,
  output logic                                    pslverr_o,
  // tcdm, one lane per port
  input  logic [NumPorts-1:0]                     tcdm_req_i,
  output logic [NumPorts-1:0]                     tcdm_gnt_o,
  input  tcdm_mem_pkg::tcdm_addr_t [NumPorts-1:0] tcdm_add_i,
  input  logic [NumPorts-1:0]                     tcdm_wen_i,
  input  tcdm_mem_pkg::tcdm_be_t [NumPorts-1:0]   tcdm_be_i,
  input  tcdm_mem_pkg::tcdm_word_t [NumPorts-1:0] tcdm_data_i,
  output tcdm_mem_pkg::tcdm_word_t [NumPorts-1:0] tcdm_r_data_o,
  output logic [NumPorts-1:0]                     tcdm_r_valid_o
);
  import tcdm_mem_pkg::*;
  import tcdm_apb_pkg::*;

  ctrl_t                     ctrl;
  logic [StallThrWidth-1:0]  stall_thr;
  logic [LfsrWidth-1:0]      seed;
  logic                      seed_load;
  logic [NumPorts-1:0][31:0] rd_cnt, wr_cnt;

  tcdm_port_if #(.MemWords(MemWords)) port_if [NumPorts] ();

  tcdm_cfg_regs #(
    .NumPorts (NumPorts)
  ) i_cfg_regs (
    .clk_i, .rst_ni,
    .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .ctrl_o      (ctrl),
    .stall_thr_o (stall_thr),
    .seed_o      (seed),
    .seed_load_o (seed_load),
    .rd_cnt_i    (rd_cnt),
    .wr_cnt_i    (wr_cnt)
  );

  for (genvar p = 0; p < NumPorts; p++) begin : gen_decode
    tcdm_req_decode #(
      .PortIdx  (p),
      .MemWords (MemWords),
      .BaseAddr (BaseAddr)
    ) i_req_decode (
      .clk_i, .rst_ni,
      .req_i       (tcdm_req_i[p]),
      .add_i       (tcdm_add_i[p]),
      .wen_i       (tcdm_wen_i[p]),
      .be_i        (tcdm_be_i[p]),
      .data_i      (tcdm_data_i[p]),
      .gnt_o       (tcdm_gnt_o[p]),
      .ctrl_i      (ctrl),
      .stall_thr_i (stall_thr),
      .seed_i      (seed),
      .seed_load_i (seed_load),
      .port        (port_if[p])
    );
  end

  tcdm_mem_bank #(
    .NumPorts (NumPorts),
    .MemWords (MemWords)
  ) i_mem_bank (
    .clk_i, .rst_ni,
    .ports (port_if)
  );

  tcdm_resp_stage #(
    .NumPorts (NumPorts)
  ) i_resp_stage (
    .clk_i, .rst_ni,
    .ports     (port_if),
    .r_data_o  (tcdm_r_data_o),
    .r_valid_o (tcdm_r_valid_o),
    .rd_cnt_o  (rd_cnt),
    .wr_cnt_o  (wr_cnt)
  );

endmodule

`default_nettype wire

/* verif/tb_tcdm_mem_top.sv */
/*
 * testbench for the tcdm scratchpad: apb registers, random byte-enable
 * traffic against a reference memory, grant stall and counters
 */
`timescale 1ns/1ps
`default_nettype none

module tb_tcdm_mem_top;
  import tcdm_mem_pkg::*;
  import tcdm_apb_pkg::*;

  localparam int unsigned NumPorts  = 2;
  localparam int unsigned MemWords  = 256;
  localparam tcdm_addr_t  BaseAddr  = '0;
  localparam int unsigned ClkPeriod = 4;
  localparam int FillTxn  = MemWords / NumPorts;
  localparam int RandTxn  = 300;
  localparam int Thr0Txn  = 60;
  localparam int StallTxn = 150;
  localparam int OtherTxn = 120; // apb accesses, reset, held requests
  localparam int TotalTxn = NumPorts * (FillTxn + RandTxn + Thr0Txn + StallTxn) + OtherTxn;

  logic                      clk_i;
  logic                      rst_ni;
  apb_addr_t                 paddr_i;
  logic                      psel_i, penable_i, pwrite_i;
  logic [31:0]               pwdata_i, prdata_o;
  logic                      pready_o, pslverr_o;
  logic [NumPorts-1:0]       tcdm_req_i, tcdm_gnt_o, tcdm_wen_i, tcdm_r_valid_o;
  tcdm_addr_t [NumPorts-1:0] tcdm_add_i;
  tcdm_be_t [NumPorts-1:0]   tcdm_be_i;
  tcdm_word_t [NumPorts-1:0] tcdm_data_i, tcdm_r_data_o;

  tcdm_word_t               ref_mem [MemWords];
  tcdm_word_t               exp_q [NumPorts][$]; // responses owed per port
  int unsigned              rd_cnt_ref [NumPorts];
  int unsigned              wr_cnt_ref [NumPorts];
  int unsigned              stalled_cycles, granted_cycles, errors;
  logic [NumPorts-1:0]      granted, gnt_d;
  ctrl_t                    shadow_ctrl;
  logic [StallThrWidth-1:0] shadow_thr;
  integer                   seed;

  tcdm_mem_top #(
    .NumPorts (NumPorts),
    .MemWords (MemWords),
    .BaseAddr (BaseAddr)
  ) dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(ClkPeriod * 20 * TotalTxn);
    report_failure("watchdog timeout, the tests did not finish in time");
  end

  task automatic end_with_failure();
    $display("TB FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
    end_with_failure();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
    end_with_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else report_mismatch(name, got, exp);
  endtask

  function automatic tcdm_word_t fill_word(input int word);
    return 32'hc300_0000 ^ (tcdm_word_t'(word) * 32'h0001_0101);
  endfunction

  function automatic tcdm_word_t merge_bytes(input tcdm_word_t old_w, input tcdm_word_t new_w,
                                             input tcdm_be_t be);
    tcdm_word_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic bit addr_in_range(input tcdm_addr_t a);
    return (a >= BaseAddr) && (((a - BaseAddr) >> 2) < MemWords);
  endfunction

  task automatic apb_write(input apb_addr_t addr, input logic [31:0] data, input bit exp_err);
    @(posedge clk_i);
    paddr_i   <= addr;
    pwdata_i  <= data;
    pwrite_i  <= 1'b1;
    psel_i    <= 1'b1;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    check_value("pready_o", pready_o, 1'b1);
    check_value("pslverr_o", pslverr_o, exp_err);
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    // dut registers take the write at this same edge
    if (!exp_err && addr == RegCtrl) shadow_ctrl <= ctrl_t'(data[1:0]);
    if (!exp_err && addr == RegStallThr) shadow_thr <= data[StallThrWidth-1:0];
  endtask

  task automatic apb_read(input apb_addr_t addr, input logic [31:0] exp_data, input bit exp_err);
    @(posedge clk_i);
    paddr_i   <= addr;
    pwrite_i  <= 1'b0;
    psel_i    <= 1'b1;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    check_value("pslverr_o", pslverr_o, exp_err);
    if (!exp_err) check_value("prdata_o", prdata_o, exp_data);
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic drive_request(input int p, input bit fill, input int word);
    int         r;
    tcdm_addr_t a;
    r = $random(seed);
    if (fill) a = BaseAddr + tcdm_addr_t'(4 * word);
    else if (r[3:0] == 4'h0) a = tcdm_addr_t'(r) | 32'h400; // beyond the array
    else if (r[4]) a = BaseAddr + tcdm_addr_t'(4 * r[9:6]); // few words, more same-word hits
    else a = BaseAddr + tcdm_addr_t'(4 * r[17:10]);
    tcdm_req_i[p]  <= 1'b1;
    tcdm_add_i[p]  <= {a[31:2], 2'b00};
    tcdm_wen_i[p]  <= fill ? 1'b0 : r[5];
    tcdm_be_i[p]   <= fill ? 4'hf : r[21:18];
    tcdm_data_i[p] <= fill ? fill_word(word) : tcdm_word_t'($random(seed));
  endtask

  // each port issues n_txn requests, holding each one until granted
  task automatic run_traffic(input int n_txn, input bit fill);
    int issued  [NumPorts];
    bit holding [NumPorts];
    bit busy;
    int r;
    for (int p = 0; p < NumPorts; p++) begin
      issued[p]  = 0;
      holding[p] = 1'b0;
    end
    busy = 1'b1;
    while (busy) begin
      @(posedge clk_i);
      busy = 1'b0;
      for (int p = 0; p < NumPorts; p++) begin
        if (holding[p] && granted[p]) holding[p] = 1'b0;
        r = $random(seed);
        if (!holding[p] && issued[p] < n_txn && (fill || r[1:0] != 2'b00)) begin
          drive_request(p, fill, issued[p] * NumPorts + p);
          issued[p]++;
          holding[p] = 1'b1;
        end else if (!holding[p]) begin
          tcdm_req_i[p] <= 1'b0; // idle cycle
        end
        if (holding[p] || issued[p] < n_txn) busy = 1'b1;
      end
    end
    tcdm_req_i <= '0; // last grants taken at this edge
  endtask

  task automatic hold_requests(input int cycles);
    @(posedge clk_i);
    for (int p = 0; p < NumPorts; p++) begin
      tcdm_add_i[p] <= BaseAddr + tcdm_addr_t'(4 * p);
      tcdm_wen_i[p] <= 1'b1;
    end
    tcdm_req_i <= '1;
    repeat (cycles) @(posedge clk_i);
    tcdm_req_i <= '0;
  endtask

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) gnt_d <= '0;
    else gnt_d <= tcdm_gnt_o;
  end

  // reference model, sampled mid-cycle while everything is settled
  always @(negedge clk_i) begin : monitor
    tcdm_word_t  exp_w [NumPorts];
    tcdm_word_t  want;
    int unsigned idx;
    if (!rst_ni) begin
      granted = '0;
    end else begin
      for (int p = 0; p < NumPorts; p++) begin
        if (tcdm_r_valid_o[p] && exp_q[p].size() == 0) begin
          report_failure($sformatf("response on port %0d with no grant pending", p));
        end else if (tcdm_r_valid_o[p]) begin
          want = exp_q[p].pop_front();
          check_value($sformatf("tcdm_r_data_o[%0d]", p), tcdm_r_data_o[p], want);
        end
      end
      granted = tcdm_gnt_o;
      for (int p = 0; p < NumPorts; p++) begin
        idx      = (tcdm_add_i[p] - BaseAddr) >> 2;
        exp_w[p] = '0; // also the out of range answer
        if (!granted[p] && tcdm_req_i[p] && shadow_ctrl.enable) stalled_cycles++;
        if (granted[p]) begin
          granted_cycles++;
          if (addr_in_range(tcdm_add_i[p]) && tcdm_wen_i[p]) exp_w[p] = ref_mem[idx];
          else if (addr_in_range(tcdm_add_i[p]))
            exp_w[p] = merge_bytes(ref_mem[idx], tcdm_data_i[p], tcdm_be_i[p]);
          exp_q[p].push_back(exp_w[p]);
          if (tcdm_wen_i[p]) rd_cnt_ref[p]++;
          else wr_cnt_ref[p]++;
        end
      end
      // higher port applied last wins a shared word
      for (int p = 0; p < NumPorts; p++) begin
        if (granted[p] && !tcdm_wen_i[p] && addr_in_range(tcdm_add_i[p]))
          ref_mem[(tcdm_add_i[p] - BaseAddr) >> 2] = exp_w[p];
      end
    end
  end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni) tcdm_r_valid_o[p] == gnt_d[p])
      else report_mismatch($sformatf("tcdm_r_valid_o[%0d]", p),
                           32'($sampled(tcdm_r_valid_o[p])), 32'($sampled(gnt_d[p])));
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      tcdm_gnt_o[p] |-> tcdm_req_i[p] && shadow_ctrl.enable)
      else report_failure($sformatf("grant on port %0d without request or enable", p));
    // no stall possible, so the grant follows req at once
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (!shadow_ctrl.stallable || shadow_thr == '0) |->
        tcdm_gnt_o[p] == (tcdm_req_i[p] && shadow_ctrl.enable))
      else report_mismatch($sformatf("tcdm_gnt_o[%0d]", p), 32'($sampled(tcdm_gnt_o[p])),
                           32'($sampled(tcdm_req_i[p] && shadow_ctrl.enable)));
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (shadow_ctrl.stallable && shadow_thr >= 1024) |-> !tcdm_gnt_o[p])
      else report_failure($sformatf("grant on port %0d while every cycle must stall", p));
  end

  initial begin : stimulus
    seed           = 32'hf2e8c454;
    errors         = 0;
    stalled_cycles = 0;
    granted_cycles = 0;
    shadow_ctrl    = '0;
    shadow_thr     = '0;
    for (int p = 0; p < NumPorts; p++) begin
      rd_cnt_ref[p] = 0;
      wr_cnt_ref[p] = 0;
    end
    rst_ni      = 1'b0;
    paddr_i     = '0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    pwdata_i    = '0;
    tcdm_req_i  = '0;
    tcdm_add_i  = '0;
    tcdm_wen_i  = '0;
    tcdm_be_i   = '0;
    tcdm_data_i = '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("tcdm_gnt_o", tcdm_gnt_o, '0);
    check_value("tcdm_r_valid_o", tcdm_r_valid_o, '0);
    check_value("prdata_o", prdata_o, '0);
    check_value("pslverr_o", pslverr_o, 1'b0);

    apb_write(RegCtrl, 32'h2, 1'b0);
    apb_read(RegCtrl, 32'h2, 1'b0);
    apb_write(RegStallThr, 32'h2a5, 1'b0);
    apb_read(RegStallThr, 32'h2a5, 1'b0);
    apb_write(RegSeed, 32'h3c5a, 1'b0);
    apb_read(RegSeed, 32'h3c5a, 1'b0);
    apb_read(12'h00c, '0, 1'b1);                // unmapped
    apb_write(12'h040, 32'h1, 1'b1);
    apb_write(RegRdCntBase, 32'h1, 1'b1);       // counters are read only
    apb_read(RegRdCntBase + 12'h00c, '0, 1'b1); // port 3 absent
    apb_read(RegWrCntBase + 12'h00c, '0, 1'b1);
    for (int p = 0; p < NumPorts; p++) begin
      apb_read(RegRdCntBase + apb_addr_t'(4 * p), '0, 1'b0);
      apb_read(RegWrCntBase + apb_addr_t'(4 * p), '0, 1'b0);
    end

    apb_write(RegCtrl, 32'h0, 1'b0);
    apb_write(RegStallThr, 32'h0, 1'b0);
    hold_requests(16); // disabled
    apb_write(RegCtrl, 32'h1, 1'b0);
    run_traffic(FillTxn, 1'b1);
    run_traffic(RandTxn, 1'b0);
    apb_write(RegCtrl, 32'h3, 1'b0);
    run_traffic(Thr0Txn, 1'b0);
    apb_write(RegStallThr, 32'd1024, 1'b0);
    hold_requests(32);
    apb_write(RegStallThr, 32'd512, 1'b0);
    stalled_cycles = 0;
    granted_cycles = 0;
    run_traffic(StallTxn, 1'b0);
    assert (stalled_cycles > 0 && granted_cycles > 0)
      else report_failure("half threshold run did not show both stalled and granted cycles");

    repeat (2) @(posedge clk_i);
    for (int p = 0; p < NumPorts; p++) begin
      assert (exp_q[p].size() == 0)
        else report_failure($sformatf("port %0d still owes responses after traffic", p));
      apb_read(RegRdCntBase + apb_addr_t'(4 * p), rd_cnt_ref[p], 1'b0);
      apb_read(RegWrCntBase + apb_addr_t'(4 * p), wr_cnt_ref[p], 1'b0);
    end

    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      end_with_failure();
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tcdm_mem_top.f */
verilog/tcdm_mem_pkg.sv
verilog/tcdm_apb_pkg.sv
verilog/tcdm_port_if.sv
verilog/tcdm_cfg_regs.sv
verilog/tcdm_req_decode.sv
verilog/tcdm_mem_bank.sv
verilog/tcdm_resp_stage.sv
verilog/tcdm_mem_top.sv
verif/tb_tcdm_mem_top.sv

/* Bender.yml */
package:
  name: tcdm_mem

sources:
  - files:
      - verilog/tcdm_mem_pkg.sv
      - verilog/tcdm_apb_pkg.sv
      - verilog/tcdm_port_if.sv
      - verilog/tcdm_cfg_regs.sv
      - verilog/tcdm_req_decode.sv
      - verilog/tcdm_mem_bank.sv
      - verilog/tcdm_resp_stage.sv
      - verilog/tcdm_mem_top.sv
  - target: test
    files:
      - verif/tb_tcdm_mem_top.sv
